// ==== source/core_pkg.sv ====
////////////////////////////////////////
// shared types and constants for the console glue logic
// everything runs in the clk_74a domain
// bridge addresses are byte addresses, one 32-bit word each
////////////////////////////////////////

package core_pkg;

  // host bridge
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // host key bitmap
  // 0 up, 1 down, 2 left, 3 right, 4 face_a, 5 face_b, 6 face_x, 7 face_y
  // 14 select, 15 start, the rest are not used here
  typedef logic [15:0] key_t;

  // console pad byte
  // 0 A, 1 B, 2 select, 3 start, 4 up, 5 down, 6 left, 7 right
  typedef logic [7:0] pad_t;

  // red in [23:16], green in [15:8], blue in [7:0]
  typedef logic [23:0] rgb_t;

  typedef logic [1:0] edge_mask_t;
  typedef logic [2:0] palette_t;

  // decoded bridge register
  typedef enum logic [2:0] {
    reg_none,
    reg_reset,
    reg_overscan,
    reg_edge_mask,
    reg_sprites,
    reg_palette,
    reg_multitap,
    reg_y_b_map
  } setting_reg_e;

  ////////////////////////////////////////
  // bridge register map

  localparam bridge_addr_t addr_reset     = 32'h0000_0050;
  localparam bridge_addr_t addr_overscan  = 32'h0000_0200;
  localparam bridge_addr_t addr_edge_mask = 32'h0000_0204;
  localparam bridge_addr_t addr_sprites   = 32'h0000_0208;
  localparam bridge_addr_t addr_palette   = 32'h0000_020C;
  localparam bridge_addr_t addr_multitap  = 32'h0000_0300;
  localparam bridge_addr_t addr_y_b_map   = 32'h0000_0310;

  ////////////////////////////////////////
  // timing

  // core reset length in clocks
  localparam int reset_cnt_w = 21;
  localparam logic [reset_cnt_w-1:0] reset_hold_cycles = 21'h10_0000;

  // hsync is pushed back so it never lands on top of vsync
  localparam int hs_cnt_w = 3;
  localparam logic [hs_cnt_w-1:0] hs_delay_cycles = 3'd7;

  // slot word layout
  localparam int slot_overscan_bit = 13;

endpackage

// ==== source/bridge_settings.sv ====
////////////////////////////////////////
// settings register bank on the host bridge
// writes only, single-cycle strobe, no back-pressure
// unmapped addresses are ignored
// a reset write holds external_reset for reset_hold_cycles
////////////////////////////////////////

module bridge_settings
  import core_pkg::*;
(
  input  logic         clk_74a,
  input  logic         pll_core_locked,
  input  logic         bridge_wr,
  input  bridge_addr_t bridge_addr,
  input  bridge_data_t bridge_wr_data,
  output logic         hide_overscan,
  output edge_mask_t   mask_vid_edges,
  output logic         allow_extra_sprites,
  output palette_t     selected_palette,
  output logic         multitap_enabled,
  output logic         y_b_map,
  output logic         external_reset
);

  setting_reg_e reg_sel;
  logic [reset_cnt_w-1:0] reset_cnt;

  // address decode, reg_none when idle or unmapped
  always_comb begin
    reg_sel = reg_none;
    if (bridge_wr) begin
      case (bridge_addr)
        addr_reset:     reg_sel = reg_reset;
        addr_overscan:  reg_sel = reg_overscan;
        addr_edge_mask: reg_sel = reg_edge_mask;
        addr_sprites:   reg_sel = reg_sprites;
        addr_palette:   reg_sel = reg_palette;
        addr_multitap:  reg_sel = reg_multitap;
        addr_y_b_map:   reg_sel = reg_y_b_map;
        default:        reg_sel = reg_none;
      endcase
    end
  end

  ////////////////////////////////////////
  // settings registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hide_overscan       <= 1'b0;
      mask_vid_edges      <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      multitap_enabled    <= 1'b0;
      y_b_map             <= 1'b0;
    end else begin
      case (reg_sel)
        reg_overscan:  hide_overscan       <= bridge_wr_data[0];
        reg_edge_mask: mask_vid_edges      <= bridge_wr_data[1:0];
        reg_sprites:   allow_extra_sprites <= bridge_wr_data[0];
        reg_palette:   selected_palette    <= bridge_wr_data[2:0];
        reg_multitap:  multitap_enabled    <= bridge_wr_data[0];
        reg_y_b_map:   y_b_map             <= bridge_wr_data[0];
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // core reset hold

  // a new reset write restarts the count
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_cnt <= '0;
    end else if (reg_sel == reg_reset) begin
      reset_cnt <= reset_hold_cycles;
    end else if (reset_cnt != '0) begin
      reset_cnt <= reset_cnt - 1'b1;
    end
  end

  // high for every nonzero count, so exactly reset_hold_cycles clocks
  assign external_reset = (reset_cnt != '0);

endmodule

// ==== source/pad_mapper.sv ====
////////////////////////////////////////
// host key bitmaps to console pad bytes
// one cycle of latency, all four players
// only player 1 takes the Y/B remap
////////////////////////////////////////

module pad_mapper
  import core_pkg::*;
(
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic y_b_map,
  input  key_t cont1_key,
  input  key_t cont2_key,
  input  key_t cont3_key,
  input  key_t cont4_key,
  output pad_t pad1,
  output pad_t pad2,
  output pad_t pad3,
  output pad_t pad4
);

  // reorder one bitmap into the pad layout
  // with remap set, A comes from face_b and B from face_y
  function automatic pad_t map_key(input key_t key, input logic remap);
    pad_t pad;
    pad[0] = remap ? key[5] : key[4];
    pad[1] = remap ? key[7] : key[5];
    pad[2] = key[14];
    pad[3] = key[15];
    // dpad keeps its order
    pad[4] = key[0];
    pad[5] = key[1];
    pad[6] = key[2];
    pad[7] = key[3];
    return pad;
  endfunction

  pad_t pad1_next;
  pad_t pad2_next;
  pad_t pad3_next;
  pad_t pad4_next;

  always_comb begin
    pad1_next = map_key(cont1_key, y_b_map);
    pad2_next = map_key(cont2_key, 1'b0);
    pad3_next = map_key(cont3_key, 1'b0);
    pad4_next = map_key(cont4_key, 1'b0);
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pad1 <= '0;
      pad2 <= '0;
      pad3 <= '0;
      pad4 <= '0;
    end else begin
      pad1 <= pad1_next;
      pad2 <= pad2_next;
      pad3 <= pad3_next;
      pad4 <= pad4_next;
    end
  end

endmodule

// ==== source/video_conditioner.sv ====
////////////////////////////////////////
// core video to scaler stream, free running
// outputs registered, one cycle behind the core
// hsync pulse comes hs_delay_cycles after its rising edge
// the slot word goes out on the first blank cycle of each line
////////////////////////////////////////

module video_conditioner
  import core_pkg::*;
(
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic hide_overscan,
  input  logic h_blank,
  input  logic v_blank,
  input  logic core_hs,
  input  logic core_vs,
  input  rgb_t core_rgb,
  output logic video_de,
  output logic video_hs,
  output logic video_vs,
  output rgb_t video_rgb
);

  logic de;
  logic de_prev;
  logic hs_prev;
  logic vs_prev;
  logic hs_rise;
  logic vs_rise;
  logic de_fall;
  rgb_t slot_word;
  logic [hs_cnt_w-1:0] hs_cnt;

  assign de      = ~(h_blank | v_blank);
  assign hs_rise = core_hs & ~hs_prev;
  assign vs_rise = core_vs & ~vs_prev;
  assign de_fall = de_prev & ~de;

  // only overscan is carried for now
  always_comb begin
    slot_word = '0;
    slot_word[slot_overscan_bit] = hide_overscan;
  end

  ////////////////////////////////////////
  // edge history

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_prev <= 1'b0;
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
    end else begin
      de_prev <= de;
      hs_prev <= core_hs;
      vs_prev <= core_vs;
    end
  end

  ////////////////////////////////////////
  // output stream

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      video_vs  <= 1'b0;
      video_hs  <= 1'b0;
      hs_cnt    <= '0;
    end else begin
      video_de <= de;

      if (de) begin
        video_rgb <= core_rgb;
      end else if (de_fall) begin
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end

      // one-cycle vsync on the core's rising edge
      video_vs <= vs_rise;

      // hsync countdown, retriggered by a new edge
      if (hs_rise) begin
        hs_cnt <= hs_delay_cycles;
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
      // flag as the count steps down to 1, pulse then sits
      // hs_delay_cycles behind the input edge like vsync sits one behind
      video_hs <= (hs_cnt == 2);
    end
  end

endmodule

// ==== source/core_top.sv ====
////////////////////////////////////////
// glue around the console core, single clock
// settings leave as plain outputs for the core
// Y/B remap and overscan stay internal
////////////////////////////////////////

module core_top
  import core_pkg::*;
(
  input  logic         clk_74a,
  input  logic         pll_core_locked,
  // host bridge, writes only
  input  logic         bridge_wr,
  input  bridge_addr_t bridge_addr,
  input  bridge_data_t bridge_wr_data,
  // settings to the core
  output edge_mask_t   mask_vid_edges,
  output logic         allow_extra_sprites,
  output palette_t     selected_palette,
  output logic         multitap_enabled,
  output logic         external_reset,
  // controllers
  input  key_t         cont1_key,
  input  key_t         cont2_key,
  input  key_t         cont3_key,
  input  key_t         cont4_key,
  output pad_t         pad1,
  output pad_t         pad2,
  output pad_t         pad3,
  output pad_t         pad4,
  // core video in
  input  logic         h_blank,
  input  logic         v_blank,
  input  logic         core_hs,
  input  logic         core_vs,
  input  rgb_t         core_rgb,
  // scaler video out
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs,
  output rgb_t         video_rgb
);

  logic y_b_map;
  logic hide_overscan;

  bridge_settings u_bridge_settings (
    .clk_74a             (clk_74a),
    .pll_core_locked     (pll_core_locked),
    .bridge_wr           (bridge_wr),
    .bridge_addr         (bridge_addr),
    .bridge_wr_data      (bridge_wr_data),
    .hide_overscan       (hide_overscan),
    .mask_vid_edges      (mask_vid_edges),
    .allow_extra_sprites (allow_extra_sprites),
    .selected_palette    (selected_palette),
    .multitap_enabled    (multitap_enabled),
    .y_b_map             (y_b_map),
    .external_reset      (external_reset)
  );

  pad_mapper u_pad_mapper (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .y_b_map         (y_b_map),
    .cont1_key       (cont1_key),
    .cont2_key       (cont2_key),
    .cont3_key       (cont3_key),
    .cont4_key       (cont4_key),
    .pad1            (pad1),
    .pad2            (pad2),
    .pad3            (pad3),
    .pad4            (pad4)
  );

  video_conditioner u_video_conditioner (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .hide_overscan   (hide_overscan),
    .h_blank         (h_blank),
    .v_blank         (v_blank),
    .core_hs         (core_hs),
    .core_vs         (core_vs),
    .core_rgb        (core_rgb),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

endmodule

// ==== tests/core_top_tb.sv ====
////////////////////////////////////////
// testbench for core_top, one clock
// stops at the first error
// reset hold runs the full 0x100000 cycles twice
////////////////////////////////////////

module core_top_tb
  import core_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_writes = 10;
  localparam int num_pixels = 11;
  localparam int num_random = 16;
  localparam int ext_gap = 1000;
  localparam int unsigned hold_timeout = int'(reset_hold_cycles) + 16;
  localparam int unsigned sync_timeout = 32;

  logic         clk_74a = 1'b0;
  logic         pll_core_locked;
  logic         bridge_wr;
  bridge_addr_t bridge_addr;
  bridge_data_t bridge_wr_data;
  edge_mask_t   mask_vid_edges;
  logic         allow_extra_sprites;
  palette_t     selected_palette;
  logic         multitap_enabled;
  logic         external_reset;
  key_t         cont1_key;
  key_t         cont2_key;
  key_t         cont3_key;
  key_t         cont4_key;
  pad_t         pad1;
  pad_t         pad2;
  pad_t         pad3;
  pad_t         pad4;
  logic         h_blank;
  logic         v_blank;
  logic         core_hs;
  logic         core_vs;
  rgb_t         core_rgb;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;
  rgb_t         video_rgb;

  integer seed = 50;

  ////////////////////////////////////////
  // bridge write table, expected settings after each write

  bridge_addr_t wr_addr [num_writes] = '{
    addr_edge_mask, addr_sprites, addr_palette, addr_multitap, 32'h0000_0400,
    32'h0000_020D, addr_edge_mask, addr_sprites, addr_palette, addr_multitap};
  bridge_data_t wr_data [num_writes] = '{
    32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFD, 32'h0000_0001, 32'hFFFF_FFFF,
    32'hFFFF_FFFF, 32'h0000_0005, 32'hFFFF_FFFE, 32'h0000_0008, 32'h0000_0002};
  edge_mask_t exp_edge [num_writes] = '{2, 2, 2, 2, 2, 2, 1, 1, 1, 1};
  logic exp_sprites [num_writes] = '{0, 1, 1, 1, 1, 1, 1, 0, 0, 0};
  palette_t exp_palette [num_writes] = '{0, 0, 5, 5, 5, 5, 5, 5, 0, 0};
  logic exp_multitap [num_writes] = '{0, 0, 0, 1, 1, 1, 1, 1, 1, 0};

  ////////////////////////////////////////
  // video table, exp_slot marks the first blank cycle after active

  logic vid_hb [num_pixels] = '{1, 0, 0, 1, 1, 0, 0, 1, 0, 1, 0};
  logic vid_vb [num_pixels] = '{0, 0, 0, 0, 0, 0, 1, 1, 0, 1, 1};
  rgb_t vid_rgb [num_pixels] = '{
    24'h111111, 24'hA1B2C3, 24'h0F0F0F, 24'h123456, 24'h654321, 24'hFFFFFF,
    24'h777777, 24'h888888, 24'h00FF00, 24'hABCDEF, 24'h010101};
  logic exp_de [num_pixels] = '{0, 1, 1, 0, 0, 1, 0, 0, 1, 0, 0};
  logic exp_slot [num_pixels] = '{0, 0, 0, 1, 0, 0, 1, 0, 0, 1, 0};

  always #2 clk_74a = ~clk_74a;

  core_top dut (.*);

  ////////////////////////////////////////
  // reporting and compare tasks

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_pad(input string name, input pad_t exp, input pad_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_setting(input string name, input bridge_data_t exp,
                               input bridge_data_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int unsigned exp,
                             input int unsigned act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers, all start and end on a falling edge

  task automatic write_bridge(input bridge_addr_t addr, input bridge_data_t data);
    bridge_wr = 1'b1;
    bridge_addr = addr;
    bridge_wr_data = data;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  task automatic count_reset_hold(output int unsigned cycles);
    cycles = 0;
    while (external_reset) begin
      cycles++;
      if (cycles > hold_timeout) begin
        report_failure("external_reset stayed high far past its hold time");
      end
      @(negedge clk_74a);
    end
  endtask

  // pad layout from the key bitmap, A/B swap to face_b/face_y when remapped
  function automatic pad_t expected_pad(input key_t key, input logic remap);
    logic btn_a;
    logic btn_b;
    btn_a = remap ? key[5] : key[4];
    btn_b = remap ? key[7] : key[5];
    return {key[3], key[2], key[1], key[0], key[15], key[14], btn_b, btn_a};
  endfunction

  task automatic run_video_table(input logic hide);
    rgb_t slot_exp;
    rgb_t rgb_exp;
    slot_exp = '0;
    slot_exp[slot_overscan_bit] = hide;
    for (int i = 0; i < num_pixels; i++) begin
      h_blank = vid_hb[i];
      v_blank = vid_vb[i];
      core_rgb = vid_rgb[i];
      @(negedge clk_74a);
      if (exp_de[i]) begin
        rgb_exp = vid_rgb[i];
      end else if (exp_slot[i]) begin
        rgb_exp = slot_exp;
      end else begin
        rgb_exp = '0;
      end
      check_bit($sformatf("video_de row %0d", i), exp_de[i], video_de);
      check_rgb($sformatf("video_rgb row %0d", i), rgb_exp, video_rgb);
    end
    h_blank = 1'b1;
    v_blank = 1'b0;
    core_rgb = '0;
  endtask

  function automatic logic sync_level(input int which);
    return (which == 0) ? video_vs : video_hs;
  endfunction

  // delay counted in falling edges from the edge that drove the sync high
  task automatic check_sync_pulse(input string name, input int which,
                                  input int unsigned exp_delay);
    int unsigned delay;
    delay = 0;
    do begin
      @(negedge clk_74a);
      delay++;
      if (delay > sync_timeout) begin
        report_failure($sformatf("%s pulse never arrived", name));
      end
    end while (!sync_level(which));
    check_count({name, " delay"}, exp_delay, delay);
    @(negedge clk_74a);
    check_bit({name, " width"}, 1'b0, sync_level(which));
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    int unsigned held;
    pll_core_locked = 1'b0;
    bridge_wr = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
    cont1_key = '0;
    cont2_key = '0;
    cont3_key = '0;
    cont4_key = '0;
    h_blank = 1'b1;
    v_blank = 1'b0;
    core_hs = 1'b0;
    core_vs = 1'b0;
    core_rgb = '0;
    repeat (5) @(negedge clk_74a);
    pll_core_locked = 1'b1;

    // state straight out of reset
    check_setting("reset mask_vid_edges", '0, bridge_data_t'(mask_vid_edges));
    check_setting("reset allow_extra_sprites", '0, bridge_data_t'(allow_extra_sprites));
    check_setting("reset selected_palette", '0, bridge_data_t'(selected_palette));
    check_setting("reset multitap_enabled", '0, bridge_data_t'(multitap_enabled));
    check_bit("reset external_reset", 1'b0, external_reset);
    check_bit("reset video_de", 1'b0, video_de);
    check_bit("reset video_hs", 1'b0, video_hs);
    check_bit("reset video_vs", 1'b0, video_vs);
    check_pad("reset pad1", '0, pad1);
    check_pad("reset pad2", '0, pad2);
    check_pad("reset pad3", '0, pad3);
    check_pad("reset pad4", '0, pad4);

    for (int i = 0; i < num_writes; i++) begin
      write_bridge(wr_addr[i], wr_data[i]);
      check_setting($sformatf("mask_vid_edges write %0d", i),
                    bridge_data_t'(exp_edge[i]), bridge_data_t'(mask_vid_edges));
      check_setting($sformatf("allow_extra_sprites write %0d", i),
                    bridge_data_t'(exp_sprites[i]), bridge_data_t'(allow_extra_sprites));
      check_setting($sformatf("selected_palette write %0d", i),
                    bridge_data_t'(exp_palette[i]), bridge_data_t'(selected_palette));
      check_setting($sformatf("multitap_enabled write %0d", i),
                    bridge_data_t'(exp_multitap[i]), bridge_data_t'(multitap_enabled));
    end

    // full hold, then a restart part way through
    write_bridge(addr_reset, 32'h0);
    check_bit("external_reset rise", 1'b1, external_reset);
    count_reset_hold(held);
    check_count("reset hold", int'(reset_hold_cycles), held);
    write_bridge(addr_reset, 32'h1);
    repeat (ext_gap) @(negedge clk_74a);
    check_bit("external_reset before restart", 1'b1, external_reset);
    write_bridge(addr_reset, 32'h0);
    count_reset_hold(held);
    check_count("restarted reset hold", int'(reset_hold_cycles), held);

    for (int mode = 0; mode < 2; mode++) begin
      write_bridge(addr_y_b_map, bridge_data_t'(mode));
      for (int i = 0; i < num_random; i++) begin
        cont1_key = key_t'($random(seed));
        cont2_key = key_t'($random(seed));
        cont3_key = key_t'($random(seed));
        cont4_key = key_t'($random(seed));
        @(negedge clk_74a);
        check_pad($sformatf("pad1 map %0d", mode), expected_pad(cont1_key, mode[0]), pad1);
        check_pad($sformatf("pad2 map %0d", mode), expected_pad(cont2_key, 1'b0), pad2);
        check_pad($sformatf("pad3 map %0d", mode), expected_pad(cont3_key, 1'b0), pad3);
        check_pad($sformatf("pad4 map %0d", mode), expected_pad(cont4_key, 1'b0), pad4);
      end
    end

    run_video_table(1'b0);
    write_bridge(addr_overscan, 32'hFFFF_FFF1);
    run_video_table(1'b1);

    // vsync trails the core edge by one cycle, hsync by its delay
    core_vs = 1'b1;
    check_sync_pulse("video_vs", 0, 1);
    core_vs = 1'b0;
    core_hs = 1'b1;
    check_sync_pulse("video_hs", 1, int'(hs_delay_cycles));
    core_hs = 1'b0;

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== src.f ====
source/core_pkg.sv
source/bridge_settings.sv
source/pad_mapper.sv
source/video_conditioner.sv
source/core_top.sv
tests/core_top_tb.sv

// ==== Bender.yml ====
package:
  name: core_glue

sources:
  - source/core_pkg.sv
  - source/bridge_settings.sv
  - source/pad_mapper.sv
  - source/video_conditioner.sv
  - source/core_top.sv
  - target: simulation
    files:
      - tests/core_top_tb.sv
